/* verilog.f */
+incdir+hw
hw/atomic_pkg.sv
hw/atomic_ctrl.sv
hw/atomic_tx_table.sv
hw/atomic_alu.sv
hw/atomic_writeback.sv
hw/atomic_handler_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_atomic_handler.sv

/* Makefile */
TOP = tb_atomic_handler

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim

run: build
	@out=$$(obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* verification/tb_atomic_handler.sv */
//////////////////////////////////////////////////
// plain traffic and atomics use separate lines in the random test
// a fence is an atomic or of zero, it waits for earlier atomics
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module tb_atomic_handler
  import atomic_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic    clock;
  logic    resetn;
  logic    arb_read;
  logic    arb_write;
  addr_t   arb_address;
  line_t   arb_writedata;
  byteen_t arb_byteenable;
  logic    arb_waitrequest;
  line_t   arb_readdata;
  logic    arb_readdatavalid;
  logic    avm_read;
  logic    avm_write;
  addr_t   avm_address;
  line_t   avm_writedata;
  byteen_t avm_byteenable;
  logic    avm_waitrequest;
  line_t   avm_readdata;
  logic    avm_readdatavalid;

  // expected memory and expected read responses
  line_t ref_mem [256];
  line_t exp_q [$];
  string test_name;
  int    errors;
  int    mark;
  int    passed;
  int    failed;

  tb_clock_gen i_clock_gen (.clock, .resetn);

  tb_mem_model i_mem (
    .clock, .resetn, .avm_read, .avm_write, .avm_address, .avm_writedata,
    .avm_byteenable, .avm_waitrequest, .avm_readdata, .avm_readdatavalid
  );

  atomic_handler_top i_atomic_handler_top (.*);

  a_reset_quiet: assert property (@(posedge clock)
    !resetn |-> (!arb_readdatavalid && !avm_read && !avm_write))
  else begin
    $display("bus activity during reset in %s", test_name);
    errors++;
  end

  // plain write reaches memory in the same cycle
  a_write_through: assert property (@(posedge clock) disable iff (!resetn)
    arb_write |-> (avm_write && avm_address == arb_address &&
                   avm_byteenable == arb_byteenable && avm_writedata == arb_writedata))
  else begin
    $display("plain write not passed straight to memory in %s", test_name);
    errors++;
  end

  a_read_return: assert property (@(posedge clock) disable iff (!resetn)
    arb_readdatavalid == avm_readdatavalid &&
    (!arb_readdatavalid || arb_readdata == avm_readdata))
  else begin
    $display("read response not returned in its cycle in %s", test_name);
    errors++;
  end

  task automatic check_line(input string what, input line_t expected, input line_t actual);
    assert (actual === expected) else begin
      $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("ERR %s %s expected %b actual %b", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout in %s: %s", test_name, what);
    errors++;
  endtask

  // responses checked in arrival order
  always @(negedge clock) begin
    if (resetn && arb_readdatavalid) begin
      if (exp_q.size() == 0) begin
        $display("read response with no read outstanding in %s", test_name);
        errors++;
      end else begin
        check_line("read data", exp_q.pop_front(), arb_readdata);
      end
    end
  end

  function automatic line_t rand_line();
    rand_line = {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // expected new word, min and max unsigned
  function automatic word_t op_result(input atomic_op_e op, input word_t old,
                                      input word_t a, input word_t b);
    case (op)
      op_add:     op_result = old + a;
      op_xchg:    op_result = a;
      op_cmpxchg: op_result = (old == a) ? b : old;
      op_min:     op_result = (a < old) ? a : old;
      op_max:     op_result = (a > old) ? a : old;
      op_and:     op_result = old & a;
      op_or:      op_result = old | a;
      default:    op_result = old ^ a;
    endcase
  endfunction

  // hold one request until arb_waitrequest drops
  // starts and ends 1 ns after a rising edge
  task automatic issue(input logic rd, input logic wr, input int unsigned line,
                       input line_t wdata, input byteen_t be);
    int   tries;
    logic taken;
    tries          = 0;
    taken          = 1'b0;
    arb_read       = rd;
    arb_write      = wr;
    arb_address    = addr_t'(line);
    arb_writedata  = wdata;
    arb_byteenable = be;
    while (!taken && tries < WAIT_LIMIT) begin
      @(negedge clock);
      taken = !arb_waitrequest;
      @(posedge clock);
      #1;
      tries++;
    end
    arb_read  = 1'b0;
    arb_write = 1'b0;
    if (!taken) begin
      note_timeout("request never accepted");
    end
  endtask

  task automatic plain_read(input int unsigned line);
    issue(1'b1, 1'b0, line, '0, '1);
    exp_q.push_back(ref_mem[line]);
  endtask

  task automatic plain_write(input int unsigned line, input line_t data, input byteen_t be);
    issue(1'b0, 1'b1, line, data, be);
    for (int b = 0; b < `ATOMIC_BYTEEN_WIDTH; b++) begin
      if (be[b]) begin
        ref_mem[line][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  // old line expected back, reference takes the result at once
  task automatic atomic_req(input int unsigned line, input atomic_op_e op,
                            input seg_t seg, input word_t a, input word_t b);
    line_t wd;
    wd = '0;
    wd[0] = 1'b1;
    wd[1 +: `ATOMIC_WORD_WIDTH] = a;
    wd[1 + `ATOMIC_WORD_WIDTH +: `ATOMIC_WORD_WIDTH] = b;
    wd[`ATOMIC_OP_LSB +: 3] = op;
    wd[`ATOMIC_SEG_LSB +: 2] = seg;
    issue(1'b1, 1'b0, line, wd, '1);
    exp_q.push_back(ref_mem[line]);
    ref_mem[line][seg*32 +: 32] = op_result(op, ref_mem[line][seg*32 +: 32], a, b);
  endtask

  task automatic drain();
    int tries;
    tries = 0;
    while (exp_q.size() != 0 && tries < WAIT_LIMIT) begin
      @(posedge clock);
      #1;
      tries++;
    end
    if (exp_q.size() != 0) begin
      note_timeout("read responses missing");
      exp_q.delete();
    end
  endtask

  task automatic fence(input int unsigned line);
    atomic_req(line, op_or, 2'd0, '0, '0);
    drain();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    mark      = errors;
  endtask

  task automatic end_test();
    if (errors == mark) begin
      $display("test %-14s ok", test_name);
      passed++;
    end else begin
      $display("test %-14s failed, %0d errors", test_name, errors - mark);
      failed++;
    end
  endtask

  initial begin
    atomic_op_e  op;
    seg_t        seg;
    word_t       a;
    word_t       start;
    word_t       sum;
    int unsigned line;
    int unsigned pick;
    int          tries;
    arb_read       = 1'b0;
    arb_write      = 1'b0;
    arb_address    = '0;
    arb_writedata  = '0;
    arb_byteenable = '0;
    errors         = 0;
    passed         = 0;
    failed         = 0;

    begin_test("reset");
    tries = 0;
    while (!resetn && tries < WAIT_LIMIT) begin
      @(posedge clock);
      tries++;
    end
    if (!resetn) begin
      note_timeout("reset never released");
    end
    #1;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = i_mem.mem[i];
    end
    // idle bus right after reset
    repeat (4) begin
      @(negedge clock);
      check_bit("readdatavalid", 1'b0, arb_readdatavalid);
      check_bit("avm_read", 1'b0, avm_read);
      check_bit("avm_write", 1'b0, avm_write);
      check_bit("waitrequest", avm_waitrequest, arb_waitrequest);
    end
    @(posedge clock);
    #1;
    end_test();

    begin_test("each_op");
    for (int k = 0; k < 8; k++) begin
      line = 10 + k;
      seg  = seg_t'(k);
      op   = atomic_op_e'(k);
      a    = (op == op_cmpxchg) ? ref_mem[line][seg*32 +: 32] : word_t'($urandom);
      atomic_req(line, op, seg, a, $urandom);
      fence(line);
    end
    // compare-exchange miss
    atomic_req(12, op_cmpxchg, 2'd1, ~ref_mem[12][63:32], $urandom);
    fence(12);
    end_test();

    begin_test("atomic_chain");
    start = ref_mem[40][95:64];
    sum   = '0;
    for (int k = 0; k < 10; k++) begin
      a   = word_t'($urandom % 1000);
      sum = sum + a;
      atomic_req(40, op_add, 2'd2, a, '0);
    end
    fence(40);
    check_line("final word", line_t'(start + sum), line_t'(i_mem.mem[40][95:64]));
    end_test();

    begin_test("plain_rw");
    plain_write(60, rand_line(), 16'h0ff3);
    plain_read(60);
    plain_write(61, rand_line(), '1);
    plain_read(61);
    plain_read(62);
    drain();
    end_test();

    begin_test("write_over");
    atomic_req(70, op_add, 2'd1, $urandom, '0);
    // bytes 5 and 6 inside the atomic word, 12 outside
    plain_write(70, rand_line(), 16'h1060);
    fence(70);
    end_test();

    begin_test("backpressure");
    for (int n = 0; n < 80; n++) begin
      pick = $urandom % 4;
      if (pick == 0) begin
        plain_read(100 + $urandom % 32);
      end else if (pick == 1) begin
        plain_write(100 + $urandom % 32, rand_line(), byteen_t'($urandom));
      end else begin
        line = 200 + $urandom % 4;
        op   = atomic_op_e'($urandom % 8);
        seg  = seg_t'($urandom % 4);
        a    = ($urandom % 2 == 0) ? ref_mem[line][seg*32 +: 32] : word_t'($urandom);
        atomic_req(line, op, seg, a, $urandom);
      end
    end
    for (int k = 200; k < 204; k++) begin
      fence(k);
    end
    drain();
    for (int i = 0; i < 256; i++) begin
      check_line($sformatf("memory line %0d", i), ref_mem[i], i_mem.mem[i]);
    end
    end_test();

    $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verification/tb_mem_model.sv */
//////////////////////////////////////////////////
// 256 lines, upper address bits ignored
// read data is taken when the read is accepted
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module tb_mem_model
  import atomic_pkg::*;
(
  input  logic    clock,
  input  logic    resetn,
  input  logic    avm_read,
  input  logic    avm_write,
  input  addr_t   avm_address,
  input  line_t   avm_writedata,
  input  byteen_t avm_byteenable,
  output logic    avm_waitrequest,
  output line_t   avm_readdata,
  output logic    avm_readdatavalid
);

  line_t       mem [256];
  line_t       data_q [$];
  int unsigned due_q [$];
  int unsigned cycle;
  int unsigned due;
  line_t       wline;

  // random fill, the only seeding of the run
  initial begin
    void'($urandom(32'h6f59));
    for (int i = 0; i < 256; i++) begin
      mem[i] = {$urandom, $urandom, $urandom, $urandom};
    end
  end

  always @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      avm_waitrequest   <= 1'b0;
      avm_readdatavalid <= 1'b0;
      avm_readdata      <= '0;
      cycle = 0;
      data_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      if (avm_write && !avm_waitrequest) begin
        wline = mem[avm_address[7:0]];
        for (int b = 0; b < `ATOMIC_BYTEEN_WIDTH; b++) begin
          if (avm_byteenable[b]) begin
            wline[b*8 +: 8] = avm_writedata[b*8 +: 8];
          end
        end
        mem[avm_address[7:0]] = wline;
      end
      // 1 to 6 cycles, never ahead of an older read
      if (avm_read && !avm_waitrequest) begin
        due = cycle + 1 + ($urandom % 6);
        if (due_q.size() > 0 && due <= due_q[$]) begin
          due = due_q[$] + 1;
        end
        data_q.push_back(mem[avm_address[7:0]]);
        due_q.push_back(due);
      end
      avm_readdatavalid <= 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        avm_readdatavalid <= 1'b1;
        avm_readdata      <= data_q.pop_front();
        void'(due_q.pop_front());
      end
      // stall about one cycle in four
      avm_waitrequest <= ($urandom % 4 == 0);
    end
  end

endmodule

/* verification/tb_clock_gen.sv */
//////////////////////////////////////////////////
// 10 ns clock and a reset held low for 3 rising edges
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic resetn
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // reset falls at 1 ns to give every async reset a clean edge
  // release 1 ns after an edge like the rest of the stimulus
  initial begin
    resetn = 1'b1;
    #1 resetn = 1'b0;
    repeat (3) @(posedge clock);
    #1 resetn = 1'b1;
  end

endmodule

/* hw/atomic_handler_top.sv */
//////////////////////////////////////////////////
// memory must answer reads in issue order, one beat per read
// no data forwarding, a second atomic to a busy line waits
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module atomic_handler_top
  import atomic_pkg::*;
(
  input  logic    clock,
  input  logic    resetn,
  // arbiter side
  input  logic    arb_read,
  input  logic    arb_write,
  input  addr_t   arb_address,
  input  line_t   arb_writedata,
  input  byteen_t arb_byteenable,
  output logic    arb_waitrequest,
  output line_t   arb_readdata,
  output logic    arb_readdatavalid,
  // memory side
  output logic    avm_read,
  output logic    avm_write,
  output addr_t   avm_address,
  output line_t   avm_writedata,
  output byteen_t avm_byteenable,
  input  logic    avm_waitrequest,
  input  line_t   avm_readdata,
  input  logic    avm_readdatavalid
);

  logic                       atomic_hit;
  logic [`ATOMIC_NUM_TXS-1:0] hit_mask;
  logic [`ATOMIC_NUM_TXS-1:0] free_mask;
  logic                       sel_writeback;
  logic                       alloc;
  slot_t                      alloc_slot;
  slot_t                      resp_slot;
  logic                       resp_atomic;
  logic                       resp_is_atomic;
  slot_t                      wb_slot;
  logic                       wb_valid;
  logic                       commit;
  atomic_op_e                 resp_op;
  word_t                      resp_operand0;
  word_t                      resp_operand1;
  seg_t                       resp_seg;
  addr_t                      wb_address;
  byteen_t                    wb_byteenable;
  seg_t                       wb_seg;
  word_t                      result;
  logic                       result_valid;

  // old line goes back untouched, even for atomics
  assign arb_readdata = avm_readdata;

  atomic_ctrl i_atomic_ctrl (
    .clock, .resetn, .arb_read, .arb_write,
    .is_atomic (arb_writedata[0]),
    .avm_waitrequest, .avm_readdatavalid, .atomic_hit, .resp_is_atomic,
    .arb_waitrequest, .avm_read, .avm_write, .sel_writeback,
    .alloc, .alloc_slot, .resp_slot, .resp_atomic,
    .wb_slot, .wb_valid, .commit, .free_mask, .arb_readdatavalid
  );

  atomic_tx_table i_atomic_tx_table (
    .clock, .resetn, .alloc, .alloc_slot,
    .arb_address, .arb_byteenable, .arb_writedata,
    .resp_slot, .wb_slot, .free_mask,
    .atomic_hit, .hit_mask, .resp_op, .resp_operand0, .resp_operand1,
    .resp_seg, .resp_is_atomic, .wb_address, .wb_byteenable, .wb_seg
  );

  atomic_alu i_atomic_alu (
    .clock, .resetn, .resp_atomic, .avm_readdata, .resp_seg,
    .resp_op, .resp_operand0, .resp_operand1,
    .result, .result_valid
  );

  atomic_writeback i_atomic_writeback (
    .clock, .resetn, .result, .result_valid, .resp_slot,
    .arb_write, .arb_byteenable, .hit_mask,
    .wb_slot, .wb_address, .wb_byteenable, .wb_seg, .sel_writeback,
    .arb_address, .arb_writedata, .free_mask,
    .avm_address, .avm_writedata, .avm_byteenable
  );

endmodule

/* hw/atomic_writeback.sv */
//////////////////////////////////////////////////
// writeback touches only the atomic's word, minus bytes taken by later writes
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module atomic_writeback
  import atomic_pkg::*;
(
  input  logic                       clock,
  input  logic                       resetn,
  input  word_t                      result,
  input  logic                       result_valid,
  input  slot_t                      resp_slot,
  input  logic                       arb_write,
  input  byteen_t                    arb_byteenable,
  input  logic [`ATOMIC_NUM_TXS-1:0] hit_mask,
  input  slot_t                      wb_slot,
  input  addr_t                      wb_address,
  input  byteen_t                    wb_byteenable,
  input  seg_t                       wb_seg,
  input  logic                       sel_writeback,
  input  addr_t                      arb_address,
  input  line_t                      arb_writedata,
  input  logic [`ATOMIC_NUM_TXS-1:0] free_mask,
  output addr_t                      avm_address,
  output line_t                      avm_writedata,
  output byteen_t                    avm_byteenable
);

  word_t   results [`ATOMIC_NUM_TXS];
  byteen_t byte_disable [`ATOMIC_NUM_TXS];
  slot_t   alu_slot;
  line_t   wb_line;
  byteen_t seg_byteen;

  // slot in the ALU is the one that got its response last cycle
  always_ff @(posedge clock) begin
    alu_slot <= resp_slot;
    if (result_valid) begin
      results[alu_slot] <= result;
    end
  end

  // plain writes over an in-flight atomic keep their bytes
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      for (int s = 0; s < `ATOMIC_NUM_TXS; s++) begin
        byte_disable[s] <= '0;
      end
    end else begin
      for (int s = 0; s < `ATOMIC_NUM_TXS; s++) begin
        if (free_mask[s]) begin
          byte_disable[s] <= '0;
        end else if (arb_write && hit_mask[s]) begin
          byte_disable[s] <= byte_disable[s] | arb_byteenable;
        end
      end
    end
  end

  // result placed in its word, enables limited to that word
  assign wb_line    = line_t'(results[wb_slot]) << (wb_seg * `ATOMIC_WORD_WIDTH);
  assign seg_byteen = byteen_t'({(`ATOMIC_WORD_WIDTH/8){1'b1}}) << (wb_seg * (`ATOMIC_WORD_WIDTH/8));

  assign avm_address    = sel_writeback ? wb_address : arb_address;
  assign avm_writedata  = sel_writeback ? wb_line : arb_writedata;
  assign avm_byteenable = sel_writeback ?
                          (wb_byteenable & seg_byteen & ~byte_disable[wb_slot]) :
                          arb_byteenable;

endmodule

/* hw/atomic_alu.sv */
//////////////////////////////////////////////////
// min and max compare unsigned
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module atomic_alu
  import atomic_pkg::*;
(
  input  logic       clock,
  input  logic       resetn,
  input  logic       resp_atomic,
  input  line_t      avm_readdata,
  input  seg_t       resp_seg,
  input  atomic_op_e resp_op,
  input  word_t      resp_operand0,
  input  word_t      resp_operand1,
  output word_t      result,
  output logic       result_valid
);

  word_t      old_word;
  word_t      opnd0_q;
  word_t      opnd1_q;
  atomic_op_e op_q;

  // capture the selected old word on the response cycle
  always_ff @(posedge clock) begin
    if (resp_atomic) begin
      old_word <= avm_readdata[resp_seg * `ATOMIC_WORD_WIDTH +: `ATOMIC_WORD_WIDTH];
      opnd0_q  <= resp_operand0;
      opnd1_q  <= resp_operand1;
      op_q     <= resp_op;
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= resp_atomic;
    end
  end

  always_comb begin
    case (op_q)
      op_add:     result = old_word + opnd0_q;
      op_xchg:    result = opnd0_q;
      // swap only on a match, else keep old value
      op_cmpxchg: result = (old_word == opnd0_q) ? opnd1_q : old_word;
      op_min:     result = (old_word < opnd0_q) ? old_word : opnd0_q;
      op_max:     result = (old_word > opnd0_q) ? old_word : opnd0_q;
      op_and:     result = old_word & opnd0_q;
      op_or:      result = old_word | opnd0_q;
      default:    result = old_word ^ opnd0_q;
    endcase
  end

endmodule

/* hw/atomic_tx_table.sv */
//////////////////////////////////////////////////
// hit checks only atomic slots, plain reads never block anything
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module atomic_tx_table
  import atomic_pkg::*;
(
  input  logic                       clock,
  input  logic                       resetn,
  input  logic                       alloc,
  input  slot_t                      alloc_slot,
  input  addr_t                      arb_address,
  input  byteen_t                    arb_byteenable,
  input  line_t                      arb_writedata,
  input  slot_t                      resp_slot,
  input  slot_t                      wb_slot,
  input  logic [`ATOMIC_NUM_TXS-1:0] free_mask,
  output logic                       atomic_hit,
  output logic [`ATOMIC_NUM_TXS-1:0] hit_mask,
  output atomic_op_e                 resp_op,
  output word_t                      resp_operand0,
  output word_t                      resp_operand1,
  output seg_t                       resp_seg,
  output logic                       resp_is_atomic,
  output addr_t                      wb_address,
  output byteen_t                    wb_byteenable,
  output seg_t                       wb_seg
);

  logic [`ATOMIC_NUM_TXS-1:0] valid;
  logic [`ATOMIC_NUM_TXS-1:0] atomic_flag;
  logic [`ATOMIC_NUM_TXS-1:0] addr_match;
  addr_t                      tx_address [`ATOMIC_NUM_TXS];
  byteen_t                    tx_byteen [`ATOMIC_NUM_TXS];
  atomic_op_e                 tx_op [`ATOMIC_NUM_TXS];
  word_t                      tx_operand0 [`ATOMIC_NUM_TXS];
  word_t                      tx_operand1 [`ATOMIC_NUM_TXS];
  seg_t                       tx_seg [`ATOMIC_NUM_TXS];

  // slot occupancy mirrors the controller FSM
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid <= '0;
    end else begin
      valid <= (valid & ~free_mask) | ({{(`ATOMIC_NUM_TXS-1){1'b0}}, alloc} << alloc_slot);
    end
  end

  // request fields decoded from writedata at allocation
  always_ff @(posedge clock) begin
    if (alloc) begin
      atomic_flag[alloc_slot] <= arb_writedata[0];
      tx_address[alloc_slot]  <= arb_address;
      tx_byteen[alloc_slot]   <= arb_byteenable;
      tx_operand0[alloc_slot] <= arb_writedata[1 +: `ATOMIC_WORD_WIDTH];
      tx_operand1[alloc_slot] <= arb_writedata[1 + `ATOMIC_WORD_WIDTH +: `ATOMIC_WORD_WIDTH];
      tx_op[alloc_slot]       <= atomic_op_e'(arb_writedata[`ATOMIC_OP_LSB +: 3]);
      tx_seg[alloc_slot]      <= arb_writedata[`ATOMIC_SEG_LSB +: $bits(seg_t)];
    end
  end

  // any active atomic on the line holds off a new atomic
  // a plain write only disables bytes that overlap the slot
  always_comb begin
    for (int s = 0; s < `ATOMIC_NUM_TXS; s++) begin
      addr_match[s] = valid[s] && atomic_flag[s] && (tx_address[s] == arb_address);
      hit_mask[s]   = addr_match[s] && ((tx_byteen[s] & arb_byteenable) != '0);
    end
  end
  assign atomic_hit = |addr_match;

  assign resp_op        = tx_op[resp_slot];
  assign resp_operand0  = tx_operand0[resp_slot];
  assign resp_operand1  = tx_operand1[resp_slot];
  assign resp_seg       = tx_seg[resp_slot];
  assign resp_is_atomic = atomic_flag[resp_slot];

  assign wb_address    = tx_address[wb_slot];
  assign wb_byteenable = tx_byteen[wb_slot];
  assign wb_seg        = tx_seg[wb_slot];

endmodule

/* hw/atomic_ctrl.sv */
//////////////////////////////////////////////////
// slots are taken round-robin, a busy slot at the pointer stalls reads
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "atomic_cfg.svh"

module atomic_ctrl
  import atomic_pkg::*;
(
  input  logic                       clock,
  input  logic                       resetn,
  input  logic                       arb_read,
  input  logic                       arb_write,
  input  logic                       is_atomic,
  input  logic                       avm_waitrequest,
  input  logic                       avm_readdatavalid,
  input  logic                       atomic_hit,
  input  logic                       resp_is_atomic,
  output logic                       arb_waitrequest,
  output logic                       avm_read,
  output logic                       avm_write,
  output logic                       sel_writeback,
  output logic                       alloc,
  output slot_t                      alloc_slot,
  output slot_t                      resp_slot,
  output logic                       resp_atomic,
  output slot_t                      wb_slot,
  output logic                       wb_valid,
  output logic                       commit,
  output logic [`ATOMIC_NUM_TXS-1:0] free_mask,
  output logic                       arb_readdatavalid
);

  tx_state_e state [`ATOMIC_NUM_TXS];
  slot_t     alloc_ptr;
  slot_t     resp_ptr;
  logic      slot_free;
  logic      send_wb;
  logic      can_read;

  // next slot in allocation order must be idle
  assign slot_free = (state[alloc_ptr] == st_idle);

  // plain write owns the port, writeback takes any other cycle
  assign send_wb = wb_valid & ~arb_write;

  // read needs a slot, no same-line atomic in flight and a free port
  assign can_read = slot_free & ~(is_atomic & atomic_hit) & ~send_wb;

  assign arb_waitrequest = avm_waitrequest | (arb_read & ~can_read);
  assign avm_read        = arb_read & can_read;
  assign avm_write       = arb_write | send_wb;
  assign sel_writeback   = send_wb;
  assign alloc           = avm_read & ~avm_waitrequest;
  assign alloc_slot      = alloc_ptr;
  assign commit          = send_wb & ~avm_waitrequest;

  // responses come back in issue order
  assign resp_slot         = resp_ptr;
  assign resp_atomic       = avm_readdatavalid & resp_is_atomic;
  assign arb_readdatavalid = avm_readdatavalid;

  // oldest writeback slot
  // age grows scanning forward from the allocation pointer
  always_comb begin
    slot_t idx;
    wb_valid = 1'b0;
    wb_slot  = alloc_ptr;
    for (int k = `ATOMIC_NUM_TXS - 1; k >= 0; k--) begin
      idx = alloc_ptr + slot_t'(k);
      if (state[idx] == st_writeback) begin
        wb_valid = 1'b1;
        wb_slot  = idx;
      end
    end
  end

  // plain read frees on its response, atomic on its commit
  always_comb begin
    for (int s = 0; s < `ATOMIC_NUM_TXS; s++) begin
      free_mask[s] = ((state[s] == st_read) && avm_readdatavalid &&
                      (resp_ptr == slot_t'(s)) && !resp_is_atomic) ||
                     ((state[s] == st_writeback) && commit && (wb_slot == slot_t'(s)));
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      alloc_ptr <= '0;
      resp_ptr  <= '0;
    end else begin
      if (alloc) begin
        alloc_ptr <= alloc_ptr + 1'b1;
      end
      if (avm_readdatavalid) begin
        resp_ptr <= resp_ptr + 1'b1;
      end
    end
  end

  // per-slot FSM
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      for (int s = 0; s < `ATOMIC_NUM_TXS; s++) begin
        state[s] <= st_idle;
      end
    end else begin
      for (int s = 0; s < `ATOMIC_NUM_TXS; s++) begin
        case (state[s])
          st_idle: begin
            if (alloc && alloc_slot == slot_t'(s)) begin
              state[s] <= st_read;
            end
          end
          st_read: begin
            if (avm_readdatavalid && resp_ptr == slot_t'(s)) begin
              state[s] <= resp_is_atomic ? st_alu : st_idle;
            end
          end
          // result lands in the writeback table this cycle
          st_alu: state[s] <= st_writeback;
          default: begin
            if (commit && wb_slot == slot_t'(s)) begin
              state[s] <= st_idle;
            end
          end
        endcase
      end
    end
  end

endmodule

/* hw/atomic_pkg.sv */
//////////////////////////////////////////////////
// op encoding must match the arbiter's op-code field
//////////////////////////////////////////////////
`include "atomic_cfg.svh"

package atomic_pkg;

  // line address and payload
  typedef logic [`ATOMIC_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`ATOMIC_DATA_WIDTH-1:0] line_t;
  typedef logic [`ATOMIC_BYTEEN_WIDTH-1:0] byteen_t;

  // atomic operand and result
  typedef logic [`ATOMIC_WORD_WIDTH-1:0] word_t;

  // slot index and word index inside a line
  typedef logic [$clog2(`ATOMIC_NUM_TXS)-1:0] slot_t;
  typedef logic [$clog2(`ATOMIC_DATA_WIDTH/`ATOMIC_WORD_WIDTH)-1:0] seg_t;

  typedef enum logic [2:0] {
    op_add     = 3'd0,
    op_xchg    = 3'd1,
    op_cmpxchg = 3'd2,
    op_min     = 3'd3,
    op_max     = 3'd4,
    op_and     = 3'd5,
    op_or      = 3'd6,
    op_xor     = 3'd7
  } atomic_op_e;

  // per-slot lifecycle
  typedef enum logic [1:0] {st_idle, st_read, st_alu, st_writeback} tx_state_e;

endpackage

/* hw/atomic_cfg.svh */
//////////////////////////////////////////////////
// one-beat 128-bit lines with 32-bit atomic words
// field positions must match the arbiter's atomic writedata encoding
//////////////////////////////////////////////////
`ifndef ATOMIC_CFG_SVH
`define ATOMIC_CFG_SVH

// reads in flight, must stay a power of two
`define ATOMIC_NUM_TXS 4

// memory line geometry
`define ATOMIC_ADDR_WIDTH 24
`define ATOMIC_DATA_WIDTH 128
`define ATOMIC_BYTEEN_WIDTH 16
`define ATOMIC_WORD_WIDTH 32

// writedata layout of an atomic read
// bit 0 flag, operand0 at 1, operand1 at 33
`define ATOMIC_OP_LSB 65
`define ATOMIC_SEG_LSB 68

`endif
